/* bench/mm_sva.sv */
module mm_sva (
	input logic clk,
	input logic rst_n_i,
	input logic rd_en_i,
	input logic ready_i,
	input logic done_i,
	input logic write_i,
	input logic idle_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// a read strobe gets its ready pulse on the following cycle
	read_gets_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
		rd_en_i |=> ready_i)
		else $error("read strobe without a ready pulse one cycle later");

	// no ready pulse shows up unless a read was taken one cycle earlier
	ready_has_read: assert property (@(posedge clk) disable iff (!rst_n_i)
		ready_i |-> $past(rd_en_i))
		else $error("ready pulse without a read one cycle earlier");

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
		done_i |=> !done_i)
		else $error("done lasted more than one cycle");

	no_write_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
		write_i |-> !idle_i)
		else $error("engine write while the controller is idle");

endmodule

// the memory instance watches the host port and the engine write against busy
bind line_mem mm_sva u_mem_sva (
	.clk     (clk),
	.rst_n_i (rst_n_i),
	.rd_en_i (host_read_i & ~eng_busy_i),
	.ready_i (host_ready_o),
	.done_i  (1'b0),
	.write_i (eng_write_i),
	.idle_i  (~eng_busy_i)
);

// engine reads are checked where the controller waits for them
bind matmul_ctrl mm_sva u_ctrl_sva (
	.clk     (clk),
	.rst_n_i (rst_n_i),
	.rd_en_i (eng_read_o),
	.ready_i (eng_ready_i),
	.done_i  (done_o),
	.write_i (1'b0),
	.idle_i  (1'b0)
);

/* bench/mm_tb.sv */
module mm_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import mm_pkg::*;

	localparam int MAT_N     = 8;
	localparam int MEM_LINES = 1024;
	localparam int TIMEOUT   = 2000;

	localparam logic [ADDR_W-1:0] A_BASE = 20'h01000;
	localparam logic [ADDR_W-1:0] B_BASE = 20'h02000;
	localparam logic [ADDR_W-1:0] C_BASE = 20'h03000;

	typedef enum int {
		OP_IDLE, OP_WR_WORD, OP_WR_BYTE, OP_RD_WORDS, OP_RD_BYTES,
		OP_MM_IDENT, OP_MM_RAND, OP_BUSY_HOST
	} op_e;

	typedef struct {
		op_e               kind;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] data;
		mem_line_u         exp;
	} row_t;

	logic              clk = 1'b0;
	logic              rst_n_i;
	logic              start_i;
	logic [ADDR_W-1:0] a_base_i;
	logic [ADDR_W-1:0] b_base_i;
	logic [ADDR_W-1:0] c_base_i;
	logic              host_read_i;
	logic              host_write_i;
	logic              host_byte_i;
	logic [ADDR_W-1:0] host_addr_i;
	logic [WORD_W-1:0] host_wdata_i;
	logic              host_ready_o;
	mem_line_u         rd_data_o;
	logic              busy_o;
	logic              done_o;

	row_t              rows[$];
	logic [WORD_W-1:0] a_m  [MAT_N][MAT_N];
	logic [WORD_W-1:0] bt_m [MAT_N][MAT_N];
	logic [WORD_W-1:0] c_m  [MAT_N][MAT_N];
	integer            seed = 32'hbf41;
	int                err_cnt = 0;
	int                check_cnt = 0;

	mm_top #(
		.MEM_LINES (MEM_LINES),
		.MAT_N     (MAT_N)
	) u_dut (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.start_i      (start_i),
		.a_base_i     (a_base_i),
		.b_base_i     (b_base_i),
		.c_base_i     (c_base_i),
		.host_read_i  (host_read_i),
		.host_write_i (host_write_i),
		.host_byte_i  (host_byte_i),
		.host_addr_i  (host_addr_i),
		.host_wdata_i (host_wdata_i),
		.host_ready_o (host_ready_o),
		.rd_data_o    (rd_data_o),
		.busy_o       (busy_o),
		.done_o       (done_o)
	);

	always #4 clk = ~clk;

	function automatic mem_line_u make_line(input logic [WORD_W-1:0] w3, w2, w1, w0);
		mem_line_u l;
		l.words[3] = w3;
		l.words[2] = w2;
		l.words[1] = w1;
		l.words[0] = w0;
		return l;
	endfunction

	task automatic add_row(input op_e kind, input logic [ADDR_W-1:0] addr,
			input logic [WORD_W-1:0] data, input mem_line_u exp);
		row_t r;
		r.kind = kind;
		r.addr = addr;
		r.data = data;
		r.exp  = exp;
		rows.push_back(r);
	endtask

	task automatic check_value(input bit ok, input string msg);
		check_cnt++;
		assert (ok) else begin
			$display("Fail %0t ns: %s", $time, msg);
			err_cnt++;
		end
	endtask

	// all host tasks start and end just after a falling edge
	task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
			input bit byte_wr);
		host_write_i = 1'b1;
		host_byte_i  = byte_wr;
		host_addr_i  = addr;
		host_wdata_i = data;
		@(negedge clk);
		host_write_i = 1'b0;
		host_byte_i  = 1'b0;
	endtask

	task automatic host_read(input logic [ADDR_W-1:0] addr, output mem_line_u got);
		int n;
		n = 0;
		got = '0;
		host_read_i = 1'b1;
		host_addr_i = addr;
		do begin
			@(negedge clk);
			host_read_i = 1'b0;
			n++;
		end while (!host_ready_o && n < 20);
		if (!host_ready_o) begin
			$display("timeout at %0t ns: no host_ready_o for the read of %h", $time, addr);
			err_cnt++;
		end else begin
			check_value(n == 1, $sformatf("host_ready_o came %0d cycles after the read", n));
			got = rd_data_o;
		end
	endtask

	task automatic compare_line(input mem_line_u got, input mem_line_u exp, input bit by_bytes);
		if (by_bytes) begin
			for (int b = 0; b < LINE_W / 8; b++) begin
				check_value(got.bytes[b] === exp.bytes[b], $sformatf(
					"byte %0d is %h, expected %h", b, got.bytes[b], exp.bytes[b]));
			end
		end else begin
			for (int k = 0; k < LANES; k++) begin
				check_value(got.words[k] === exp.words[k], $sformatf(
					"word %0d is %h, expected %h", k, got.words[k], exp.words[k]));
			end
		end
	endtask

	// A row-major and B transposed, one word write per element
	task automatic load_matrices(input bit ident);
		for (int r = 0; r < MAT_N; r++) begin
			for (int k = 0; k < MAT_N; k++) begin
				a_m[r][k]  = ident ? WORD_W'(r == k) : $random(seed);
				bt_m[r][k] = $random(seed);
				host_write(A_BASE + ADDR_W'(4 * (r * MAT_N + k)), a_m[r][k], 1'b0);
				host_write(B_BASE + ADDR_W'(4 * (r * MAT_N + k)), bt_m[r][k], 1'b0);
			end
		end
	endtask

	// with A the identity, C(i,j) is just element (j,i) of the B transposed storage
	task automatic predict_product(input bit ident);
		logic [WORD_W-1:0] sum;
		for (int i = 0; i < MAT_N; i++) begin
			for (int j = 0; j < MAT_N; j++) begin
				sum = '0;
				for (int k = 0; k < MAT_N; k++) begin
					sum = sum + a_m[i][k] * bt_m[j][k];
				end
				c_m[i][j] = ident ? bt_m[j][i] : sum;
			end
		end
	endtask

	task automatic run_engine(input bit poke, input logic [ADDR_W-1:0] addr,
			input logic [WORD_W-1:0] data);
		int n;
		bit seen_done;
		n = 0;
		seen_done = 1'b0;
		a_base_i = A_BASE;
		b_base_i = B_BASE;
		c_base_i = C_BASE;
		start_i  = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		check_value(busy_o, "busy_o did not rise after start_i");
		while (!seen_done && n < TIMEOUT) begin
			// a host write and then a host read in the middle of the run
			host_write_i = poke && (n == 3);
			host_read_i  = poke && (n == 4);
			host_addr_i  = addr;
			host_wdata_i = data;
			@(negedge clk);
			n++;
			if (poke) begin
				check_value(!host_ready_o, "host_ready_o pulsed while busy_o was high");
			end
			if (done_o) begin
				seen_done = 1'b1;
				check_value(!busy_o, "busy_o still high together with done_o");
			end else begin
				check_value(busy_o, "busy_o fell before done_o");
			end
		end
		host_write_i = 1'b0;
		host_read_i  = 1'b0;
		if (!seen_done) begin
			$display("timeout at %0t ns: done_o never came after start_i", $time);
			err_cnt++;
		end
	endtask

	task automatic check_product();
		mem_line_u got;
		for (int i = 0; i < MAT_N; i++) begin
			for (int l = 0; l < MAT_N / 4; l++) begin
				host_read(C_BASE + ADDR_W'(16 * (i * MAT_N / 4 + l)), got);
				for (int k = 0; k < LANES; k++) begin
					check_value(got.words[k] === c_m[i][4 * l + k], $sformatf(
						"C(%0d,%0d) is %h, expected %h", i, 4 * l + k,
						got.words[k], c_m[i][4 * l + k]));
				end
			end
		end
	endtask

	initial begin
		mem_line_u got;
		mem_line_u none;
		int err_before;
		rst_n_i      = 1'b0;
		start_i      = 1'b0;
		a_base_i     = '0;
		b_base_i     = '0;
		c_base_i     = '0;
		host_read_i  = 1'b0;
		host_write_i = 1'b0;
		host_byte_i  = 1'b0;
		host_addr_i  = '0;
		host_wdata_i = '0;
		none = '0;

		// byte 13 of line 0x100 is byte 1 of word 3
		add_row(OP_IDLE, 20'h0, 32'h0, none);
		add_row(OP_WR_WORD, 20'h00100, 32'h11111111, none);
		add_row(OP_WR_WORD, 20'h00104, 32'h22222222, none);
		add_row(OP_WR_WORD, 20'h00108, 32'h33333333, none);
		add_row(OP_WR_WORD, 20'h0010c, 32'h44444444, none);
		add_row(OP_RD_WORDS, 20'h00100, 32'h0,
			make_line(32'h44444444, 32'h33333333, 32'h22222222, 32'h11111111));
		add_row(OP_WR_WORD, 20'h00108, 32'ha5a5a5a5, none);
		add_row(OP_RD_WORDS, 20'h00100, 32'h0,
			make_line(32'h44444444, 32'ha5a5a5a5, 32'h22222222, 32'h11111111));
		add_row(OP_WR_BYTE, 20'h0010d, 32'hdeadbe7e, none);
		add_row(OP_RD_BYTES, 20'h00100, 32'h0,
			make_line(32'h44447e44, 32'ha5a5a5a5, 32'h22222222, 32'h11111111));
		add_row(OP_WR_BYTE, 20'h00100, 32'h000000c3, none);
		add_row(OP_RD_BYTES, 20'h00100, 32'h0,
			make_line(32'h44447e44, 32'ha5a5a5a5, 32'h22222222, 32'h111111c3));
		add_row(OP_MM_IDENT, 20'h0, 32'h0, none);
		add_row(OP_MM_RAND, 20'h0, 32'h0, none);
		add_row(OP_BUSY_HOST, 20'h00100, 32'h0badf00d,
			make_line(32'h44447e44, 32'ha5a5a5a5, 32'h22222222, 32'h111111c3));

		repeat (8) @(negedge clk);
		rst_n_i = 1'b1;
		@(negedge clk);

		foreach (rows[t]) begin
			err_before = err_cnt;
			case (rows[t].kind)
				OP_IDLE: begin
					check_value(!busy_o, "busy_o high after reset");
					check_value(!done_o, "done_o high after reset");
					check_value(!host_ready_o, "host_ready_o high after reset");
				end
				OP_WR_WORD: host_write(rows[t].addr, rows[t].data, 1'b0);
				OP_WR_BYTE: host_write(rows[t].addr, rows[t].data, 1'b1);
				OP_RD_WORDS, OP_RD_BYTES: begin
					host_read(rows[t].addr, got);
					compare_line(got, rows[t].exp, rows[t].kind == OP_RD_BYTES);
				end
				OP_MM_IDENT, OP_MM_RAND: begin
					load_matrices(rows[t].kind == OP_MM_IDENT);
					predict_product(rows[t].kind == OP_MM_IDENT);
					run_engine(1'b0, '0, '0);
					check_product();
				end
				OP_BUSY_HOST: begin
					run_engine(1'b1, rows[t].addr, rows[t].data);
					host_read(rows[t].addr, got);
					compare_line(got, rows[t].exp, 1'b0);
				end
				default: check_value(1'b0, "unknown table row");
			endcase
			$display("test %0d %s %s", t, rows[t].kind.name(),
				(err_cnt == err_before) ? "passed" : "failed");
		end

		$display("%0d tests, %0d checks, %0d errors", rows.size(), check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* source/dot_unit.sv */
module dot_unit (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      acc_clear_i,
	input  logic                      a_load_i,
	input  logic                      b_load_i,
	input  mm_pkg::mem_line_u         line_i,
	output logic [mm_pkg::WORD_W-1:0] acc_o
);

	import mm_pkg::*;

	// A line held until its partner line from B transposed arrives
	mem_line_u a_line;

	logic [WORD_W-1:0] lane_sum;

	always_ff @(posedge clk) begin
		if (a_load_i) begin
			a_line <= line_i;
		end
	end

	// four lane products added together, everything wraps at 32 bits
	always_comb begin
		lane_sum = '0;
		for (int k = 0; k < LANES; k++) begin
			lane_sum = lane_sum + a_line.words[k] * line_i.words[k];
		end
	end

	// a clear wins over a load arriving in the same cycle
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc_o <= '0;
		end else if (acc_clear_i) begin
			acc_o <= '0;
		end else if (b_load_i) begin
			acc_o <= acc_o + lane_sum;
		end
	end

endmodule

/* source/line_mem.sv */
module line_mem #(
	parameter int MEM_LINES = 1024
) (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      eng_read_i,
	input  logic [mm_pkg::ADDR_W-1:0] eng_read_addr_i,
	input  logic                      eng_write_i,
	input  logic [mm_pkg::ADDR_W-1:0] eng_write_addr_i,
	input  logic [mm_pkg::WORD_W-1:0] eng_wdata_i,
	input  logic                      host_read_i,
	input  logic                      host_write_i,
	input  logic                      host_byte_i,
	input  logic [mm_pkg::ADDR_W-1:0] host_addr_i,
	input  logic [mm_pkg::WORD_W-1:0] host_wdata_i,
	input  logic                      eng_busy_i,
	output logic                      eng_ready_o,
	output logic                      host_ready_o,
	output mm_pkg::mem_line_u         rd_data_o
);

	import mm_pkg::*;

	// line index bits taken from the address just above the byte offset
	localparam int IDX_W = $clog2(MEM_LINES);

	mem_line_u mem [MEM_LINES];

	logic              rd_en;
	logic [ADDR_W-1:0] rd_addr;
	logic              wr_en;
	logic              wr_byte;
	logic [ADDR_W-1:0] wr_addr;
	logic [WORD_W-1:0] wr_data;
	logic [IDX_W-1:0]  rd_line;
	logic [IDX_W-1:0]  wr_line;

	// remembers a read in flight and which port asked for it
	logic rd_valid;
	logic rd_from_eng;

	// the engine owns the memory while it is busy, host strobes are dropped
	always_comb begin
		if (eng_busy_i) begin
			rd_en   = eng_read_i;
			rd_addr = eng_read_addr_i;
			wr_en   = eng_write_i;
			wr_byte = 1'b0;
			wr_addr = eng_write_addr_i;
			wr_data = eng_wdata_i;
		end else begin
			rd_en   = host_read_i;
			rd_addr = host_addr_i;
			wr_en   = host_write_i;
			wr_byte = host_byte_i;
			wr_addr = host_addr_i;
			wr_data = host_wdata_i;
		end
	end

	assign rd_line = rd_addr[4 +: IDX_W];
	assign wr_line = wr_addr[4 +: IDX_W];

	// write merge through the union, only the selected word or byte changes
	always_ff @(posedge clk) begin
		if (wr_en) begin
			if (wr_byte) begin
				mem[wr_line].bytes[wr_addr[3:0]] <= wr_data[7:0];
			end else begin
				mem[wr_line].words[wr_addr[3:2]] <= wr_data;
			end
		end
	end

	// the line read here was written at an earlier edge at the latest
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data_o <= mem[rd_line];
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_valid    <= 1'b0;
			rd_from_eng <= 1'b0;
		end else begin
			rd_valid    <= rd_en;
			rd_from_eng <= eng_busy_i;
		end
	end

	// one ready pulse per read, steered back to the port that issued it
	assign eng_ready_o  = rd_valid & rd_from_eng;
	assign host_ready_o = rd_valid & ~rd_from_eng;

endmodule

/* source/matmul_ctrl.sv */
module matmul_ctrl #(
	parameter int MAT_N = 8
) (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      start_i,
	input  logic [mm_pkg::ADDR_W-1:0] a_base_i,
	input  logic [mm_pkg::ADDR_W-1:0] b_base_i,
	input  logic [mm_pkg::ADDR_W-1:0] c_base_i,
	input  logic                      eng_ready_i,
	input  logic [mm_pkg::WORD_W-1:0] acc_i,
	output logic                      eng_read_o,
	output logic [mm_pkg::ADDR_W-1:0] eng_read_addr_o,
	output logic                      eng_write_o,
	output logic [mm_pkg::ADDR_W-1:0] eng_write_addr_o,
	output logic [mm_pkg::WORD_W-1:0] eng_wdata_o,
	output logic                      acc_clear_o,
	output logic                      a_load_o,
	output logic                      b_load_o,
	output logic                      busy_o,
	output logic                      done_o
);

	import mm_pkg::*;

	// i, j and the line index all fit below MAT_N
	localparam int IDX_W = $clog2(MAT_N);

	// lines per matrix row
	localparam int ROW_LINES = MAT_N / 4;

	localparam logic [2:0] IDLE   = 3'd0;
	localparam logic [2:0] READ_A = 3'd1;
	localparam logic [2:0] WAIT_A = 3'd2;
	localparam logic [2:0] READ_B = 3'd3;
	localparam logic [2:0] WAIT_B = 3'd4;
	localparam logic [2:0] WRITE  = 3'd5;
	localparam logic [2:0] DONE   = 3'd6;

	logic [2:0] state;

	logic [IDX_W-1:0] row_i;
	logic [IDX_W-1:0] col_j;
	logic [IDX_W-1:0] line_l;

	logic [ADDR_W-1:0] a_base_q;
	logic [ADDR_W-1:0] b_base_q;
	logic [ADDR_W-1:0] c_base_q;

	logic [ADDR_W-1:0] a_off;
	logic [ADDR_W-1:0] b_off;
	logic [ADDR_W-1:0] c_off;

	logic start_ok;
	logic last_line;
	logic last_col;
	logic last_row;

	// busy is low in DONE, so a new start is taken there as well
	assign start_ok = start_i & ((state == IDLE) | (state == DONE));

	assign last_line = (line_l == IDX_W'(ROW_LINES - 1));
	assign last_col  = (col_j == IDX_W'(MAT_N - 1));
	assign last_row  = (row_i == IDX_W'(MAT_N - 1));

	// line offsets in units of lines, element offset in units of words
	always_comb begin
		a_off = ADDR_W'(row_i) * ADDR_W'(ROW_LINES) + ADDR_W'(line_l);
		b_off = ADDR_W'(col_j) * ADDR_W'(ROW_LINES) + ADDR_W'(line_l);
		c_off = ADDR_W'(row_i) * ADDR_W'(MAT_N) + ADDR_W'(col_j);
	end

	assign eng_read_o       = (state == READ_A) | (state == READ_B);
	assign eng_read_addr_o  = (state == READ_A) ? a_base_q + (a_off << 4) :
	                                              b_base_q + (b_off << 4);
	assign eng_write_o      = (state == WRITE);
	assign eng_write_addr_o = c_base_q + (c_off << 2);
	assign eng_wdata_o      = acc_i;

	// the result is sampled by the memory on the same edge that clears it
	assign acc_clear_o = start_ok | (state == WRITE);
	assign a_load_o    = (state == WAIT_A) & eng_ready_i;
	assign b_load_o    = (state == WAIT_B) & eng_ready_i;

	assign busy_o = (state != IDLE) & (state != DONE);
	assign done_o = (state == DONE);

	always_ff @(posedge clk) begin
		if (start_ok) begin
			a_base_q <= a_base_i;
			b_base_q <= b_base_i;
			c_base_q <= c_base_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state  <= IDLE;
			row_i  <= '0;
			col_j  <= '0;
			line_l <= '0;
		end else begin
			case (state)
				IDLE, DONE: begin
					if (start_ok) begin
						row_i  <= '0;
						col_j  <= '0;
						line_l <= '0;
						state  <= READ_A;
					end else begin
						state <= IDLE;
					end
				end
				READ_A: state <= WAIT_A;
				WAIT_A: begin
					if (eng_ready_i) begin
						state <= READ_B;
					end
				end
				READ_B: state <= WAIT_B;
				WAIT_B: begin
					if (eng_ready_i) begin
						if (last_line) begin
							line_l <= '0;
							state  <= WRITE;
						end else begin
							line_l <= line_l + 1'b1;
							state  <= READ_A;
						end
					end
				end
				WRITE: begin
					// step j first, then i, and stop after the last element
					if (last_col) begin
						col_j <= '0;
						if (last_row) begin
							row_i <= '0;
							state <= DONE;
						end else begin
							row_i <= row_i + 1'b1;
							state <= READ_A;
						end
					end else begin
						col_j <= col_j + 1'b1;
						state <= READ_A;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* source/mm_pkg.sv */
package mm_pkg;

	// byte address width shared by the host port and the engine port
	parameter int ADDR_W = 20;

	// one memory line holds four matrix elements
	parameter int LINE_W = 128;

	// width of a matrix element, of a write datum and of the accumulator
	parameter int WORD_W = 32;

	// number of words in one line, which is also the dot unit lane count
	parameter int LANES = 4;

	// a memory line as the engine sees it (four words) and as byte writes
	// see it (sixteen bytes)
	// word 0 and byte 0 sit at the low end of the line, so the word index is
	// address bits 3:2 and the byte index is address bits 3:0
	typedef union packed {
		logic [LANES-1:0][WORD_W-1:0] words;
		logic [LINE_W/8-1:0][7:0]     bytes;
	} mem_line_u;

endpackage

/* source/mm_top.sv */
module mm_top #(
	parameter int MEM_LINES = 1024,
	parameter int MAT_N     = 8
) (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      start_i,
	input  logic [mm_pkg::ADDR_W-1:0] a_base_i,
	input  logic [mm_pkg::ADDR_W-1:0] b_base_i,
	input  logic [mm_pkg::ADDR_W-1:0] c_base_i,
	input  logic                      host_read_i,
	input  logic                      host_write_i,
	input  logic                      host_byte_i,
	input  logic [mm_pkg::ADDR_W-1:0] host_addr_i,
	input  logic [mm_pkg::WORD_W-1:0] host_wdata_i,
	output logic                      host_ready_o,
	output mm_pkg::mem_line_u         rd_data_o,
	output logic                      busy_o,
	output logic                      done_o
);

	import mm_pkg::*;

	// engine port between controller and memory
	logic              eng_read;
	logic [ADDR_W-1:0] eng_read_addr;
	logic              eng_write_enable;
	logic [ADDR_W-1:0] eng_write_addr;
	logic [WORD_W-1:0] eng_write_data;
	logic              eng_ready;

	// controller to dot unit
	logic              acc_clear;
	logic              a_load;
	logic              b_load;
	logic [WORD_W-1:0] acc;

	line_mem #(
		.MEM_LINES (MEM_LINES)
	) u_mem (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.eng_read_i       (eng_read),
		.eng_read_addr_i  (eng_read_addr),
		.eng_write_i      (eng_write_enable),
		.eng_write_addr_i (eng_write_addr),
		.eng_wdata_i      (eng_write_data),
		.host_read_i      (host_read_i),
		.host_write_i     (host_write_i),
		.host_byte_i      (host_byte_i),
		.host_addr_i      (host_addr_i),
		.host_wdata_i     (host_wdata_i),
		.eng_busy_i       (busy_o),
		.eng_ready_o      (eng_ready),
		.host_ready_o     (host_ready_o),
		.rd_data_o        (rd_data_o)
	);

	matmul_ctrl #(
		.MAT_N (MAT_N)
	) u_ctrl (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.start_i          (start_i),
		.a_base_i         (a_base_i),
		.b_base_i         (b_base_i),
		.c_base_i         (c_base_i),
		.eng_ready_i      (eng_ready),
		.acc_i            (acc),
		.eng_read_o       (eng_read),
		.eng_read_addr_o  (eng_read_addr),
		.eng_write_o      (eng_write_enable),
		.eng_write_addr_o (eng_write_addr),
		.eng_wdata_o      (eng_write_data),
		.acc_clear_o      (acc_clear),
		.a_load_o         (a_load),
		.b_load_o         (b_load),
		.busy_o           (busy_o),
		.done_o           (done_o)
	);

	// the shared read bus feeds the dot unit directly
	dot_unit u_dot (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.acc_clear_i (acc_clear),
		.a_load_i    (a_load),
		.b_load_i    (b_load),
		.line_i      (rd_data_o),
		.acc_o       (acc)
	);

endmodule

/* verilog.f */
source/mm_pkg.sv
source/line_mem.sv
source/dot_unit.sv
source/matmul_ctrl.sv
source/mm_top.sv
bench/mm_sva.sv
bench/mm_tb.sv
